/* files.f */
+incdir+common
common/feature_pkg.sv
source/row_ram.sv
source/feature_sequencer.sv
blur/line_buffer.sv
blur/gaussian_blur.sv
detect/keypoint_detector.sv
source/feature_core.sv
verification/feature_core_assertions.sv
verification/feature_core_tb.sv

/* Makefile */
TOP := feature_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* verification/feature_core_tb.sv */
`timescale 1ns/100ps
`include "feature_cfg.svh"

module feature_core_tb;
    import feature_pkg::*;

    localparam int ROWS        = `FC_IMG_ROWS;
    localparam int COLS        = `FC_IMG_COLS;
    localparam int RUN_TIMEOUT = 2000;    // cycles, a run needs about 300

    logic      clk;
    logic      rst_n;
    logic      start;
    img_load_t img_load;
    logic      filter_on;
    thresh_t   filter_threshold;
    kp_addr_t  kp_rd_addr;
    keypoint_t kp_rd_data;
    kp_count_t kp_count;
    logic      done;

    pixel_t    image [ROWS][COLS];    // host copy of the image memory
    keypoint_t kp_ref [$];            // every hit of the model, raster order
    int        error_count;

    feature_core i_feature_core (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .img_load         (img_load),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .kp_rd_addr       (kp_rd_addr),
        .kp_rd_data       (kp_rd_data),
        .kp_count         (kp_count),
        .done             (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(input string test, input kp_count_t expected,
                               input kp_count_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: count expected %0d actual %0d",
                                     test, expected, actual));
        end
    endtask

    task automatic check_keypoint(input string test, input keypoint_t expected,
                                  input keypoint_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: keypoint expected (%0d,%0d) actual (%0d,%0d)",
                                     test, expected.row, expected.col, actual.row, actual.col));
        end
    endtask

    task automatic check_done(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: done expected %b actual %b",
                                     test, expected, actual));
        end
    endtask

    function automatic int pixel_at(input int r, input int c);
        if (r < 0 || r >= ROWS || c < 0 || c >= COLS) begin
            return 0;    // zero padding outside the image
        end
        return int'(image[r][c]);
    endfunction

    // 1-2-1 by 1-2-1 blur, /16 truncated, then |pixel - blur| > threshold
    task automatic build_reference(input logic use_filter, input thresh_t level);
        int        sum;
        int        diff;
        int        limit;
        int        w;
        keypoint_t kp;
        kp_ref.delete();
        limit = use_filter ? int'(level) : `FC_BASE_THRESH;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                sum = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                        sum += w * pixel_at(r + dr, c + dc);
                    end
                end
                diff = int'(image[r][c]) - sum / 16;
                if (diff < 0) begin
                    diff = -diff;
                end
                if (diff > limit) begin
                    kp.row = row_addr_t'(r);
                    kp.col = col_addr_t'(c);
                    kp_ref.push_back(kp);
                end
            end
        end
    endtask

    task automatic fill_flat(input pixel_t value);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                image[r][c] = value;
            end
        end
    endtask

    task automatic fill_random(input int base, input int unsigned span);
        int unsigned pick;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                pick = $urandom();
                image[r][c] = pixel_t'(base + int'(pick % span));
            end
        end
    endtask

    task automatic load_image();
        img_row_t row_bits;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                row_bits[c*`FC_PIX_W +: `FC_PIX_W] = image[r][c];    // column 0 low
            end
            @(posedge clk);
            img_load <= '{we: 1'b1, addr: row_addr_t'(r), data: row_bits};
        end
        @(posedge clk);
        img_load.we <= 1'b0;
    endtask

    task automatic set_filter(input logic on, input thresh_t level);
        @(posedge clk);
        filter_on        <= on;
        filter_threshold <= level;
    endtask

    task automatic run_and_wait(input string test);
        int cycles;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        @(negedge clk);
        check_done(test, 1'b0, done);    // accepted start leaves the done phase
        while (!done) begin
            if (cycles > RUN_TIMEOUT) begin
                report_failure($sformatf("%s: done did not rise within %0d cycles",
                                         test, RUN_TIMEOUT));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_results(input string test);
        int n;
        n = (kp_ref.size() > `FC_KP_DEPTH) ? `FC_KP_DEPTH : kp_ref.size();
        check_count(test, kp_count_t'(n), kp_count);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            kp_rd_addr <= kp_addr_t'(i);
            @(posedge clk);
            @(negedge clk);    // read data one cycle after the address
            check_keypoint(test, kp_ref[i], kp_rd_data);
        end
        check_done(test, 1'b1, done);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_done("reset", 1'b0, done);
        check_count("reset", '0, kp_count);
    endtask

    task automatic test_flat_base();
        fill_flat(8'd100);
        load_image();
        set_filter(1'b0, 8'd0);
        build_reference(1'b0, 8'd0);
        check_count("flat_base model", kp_count_t'(60), kp_count_t'(kp_ref.size()));
        run_and_wait("flat_base");
        check_results("flat_base");
    endtask

    task automatic test_flat_filter();
        set_filter(1'b1, 8'd50);    // above both edge and corner differences
        build_reference(1'b1, 8'd50);
        check_count("flat_t50 model", '0, kp_count_t'(kp_ref.size()));
        run_and_wait("flat_t50");
        check_results("flat_t50");
        set_filter(1'b1, 8'd30);    // corners only, 44 against 25 on edges
        build_reference(1'b1, 8'd30);
        check_count("flat_t30 model", kp_count_t'(4), kp_count_t'(kp_ref.size()));
        run_and_wait("flat_t30");
        check_results("flat_t30");
    endtask

    task automatic test_random_saturate();
        fill_random(0, 256);
        load_image();
        set_filter(1'b0, 8'd0);
        build_reference(1'b0, 8'd0);
        run_and_wait("random_full");
        check_results("random_full");
    endtask

    task automatic test_reload_in_done();
        fill_random(120, 24);
        load_image();
        set_filter(1'b1, 8'd6);
        @(negedge clk);
        check_done("reload", 1'b1, done);    // host still owns the memories
        build_reference(1'b1, 8'd6);
        run_and_wait("reload");
        check_results("reload");
    endtask

    initial begin
        void'($urandom(42));
        error_count      = 0;
        rst_n            = 1'b0;
        start            = 1'b0;
        img_load         = '0;
        filter_on        = 1'b0;
        filter_threshold = '0;
        kp_rd_addr       = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_flat_base();
        test_flat_filter();
        test_random_saturate();
        test_reload_in_done();

        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verification/feature_core_assertions.sv */
`timescale 1ns/100ps
`include "feature_cfg.svh"

module feature_core_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   start,
    input feature_pkg::phase_e    phase,
    input logic                   done,
    input feature_pkg::kp_count_t kp_count
);
    import feature_pkg::*;

    logic start_taken;

    assign start_taken = start && ((phase == PH_IDLE) || (phase == PH_DONE));

    // a run always spans blur and detect
    assert property (@(posedge clk) disable iff (!rst_n) start_taken |=> !done)
        else $error("done high in the cycle after an accepted start");

    assert property (@(posedge clk) disable iff (!rst_n)
                     kp_count <= kp_count_t'(`FC_KP_DEPTH))
        else $error("keypoint count above the store depth");

    assert property (@(posedge clk) disable iff (!rst_n) done && !start |=> done)
        else $error("done dropped without a start");

endmodule

bind feature_core feature_core_assertions i_feature_core_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .phase    (phase),
    .done     (done),
    .kp_count (kp_count)
);

/* source/feature_core.sv */
`timescale 1ns/100ps
`include "feature_cfg.svh"

module feature_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  feature_pkg::img_load_t img_load,
    input  logic                   filter_on,
    input  feature_pkg::thresh_t   filter_threshold,
    input  feature_pkg::kp_addr_t  kp_rd_addr,
    output feature_pkg::keypoint_t kp_rd_data,
    output feature_pkg::kp_count_t kp_count,
    output logic                   done
);
    import feature_pkg::*;

    phase_e    phase;
    logic      blur_start;
    logic      detect_start;
    logic      blur_done;
    logic      detect_done;
    logic      img_we;
    row_addr_t img_addr;
    img_row_t  img_dout;
    row_addr_t blur_img_addr;
    logic      blur_we;
    row_addr_t blur_wr_addr;
    img_row_t  blur_din;
    img_row_t  blur_dout;
    row_addr_t blur_mem_addr;
    row_addr_t det_row_addr;
    logic      kp_we;
    kp_addr_t  kp_addr;
    kp_addr_t  det_kp_addr;
    keypoint_t kp_din;

    // blurred store is written in blur, read by the detector in detect
    assign blur_mem_addr = (phase == PH_DETECT) ? det_row_addr : blur_wr_addr;

    feature_sequencer i_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .img_load      (img_load),
        .blur_done     (blur_done),
        .detect_done   (detect_done),
        .blur_img_addr (blur_img_addr),
        .det_img_addr  (det_row_addr),
        .kp_rd_addr    (kp_rd_addr),
        .det_kp_addr   (det_kp_addr),
        .phase         (phase),
        .blur_start    (blur_start),
        .detect_start  (detect_start),
        .img_we        (img_we),
        .img_addr      (img_addr),
        .kp_addr       (kp_addr),
        .done          (done)
    );

    gaussian_blur i_blur (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (blur_start),
        .img_dout  (img_dout),
        .img_addr  (blur_img_addr),
        .blur_we   (blur_we),
        .blur_addr (blur_wr_addr),
        .blur_din  (blur_din),
        .done      (blur_done)
    );

    keypoint_detector i_detector (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (detect_start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .img_dout         (img_dout),
        .blur_dout        (blur_dout),
        .row_addr         (det_row_addr),
        .kp_we            (kp_we),
        .kp_addr          (det_kp_addr),
        .kp_din           (kp_din),
        .kp_count         (kp_count),
        .done             (detect_done)
    );

    row_ram #(.WIDTH(`FC_IMG_COLS*`FC_PIX_W), .DEPTH(`FC_IMG_ROWS)) i_img_ram (
        .clk  (clk),
        .we   (img_we),
        .addr (img_addr),
        .din  (img_load.data),
        .dout (img_dout)
    );

    row_ram #(.WIDTH(`FC_IMG_COLS*`FC_PIX_W), .DEPTH(`FC_IMG_ROWS)) i_blur_ram (
        .clk  (clk),
        .we   (blur_we),
        .addr (blur_mem_addr),
        .din  (blur_din),
        .dout (blur_dout)
    );

    row_ram #(.WIDTH($bits(keypoint_t)), .DEPTH(`FC_KP_DEPTH)) i_kp_ram (
        .clk  (clk),
        .we   (kp_we),
        .addr (kp_addr),
        .din  (kp_din),
        .dout (kp_rd_data)
    );

endmodule

/* detect/keypoint_detector.sv */
`timescale 1ns/100ps
`include "feature_cfg.svh"

module keypoint_detector (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   filter_on,
    input  feature_pkg::thresh_t   filter_threshold,
    input  feature_pkg::img_row_t  img_dout,
    input  feature_pkg::img_row_t  blur_dout,
    output feature_pkg::row_addr_t row_addr,
    output logic                   kp_we,
    output feature_pkg::kp_addr_t  kp_addr,
    output feature_pkg::keypoint_t kp_din,
    output feature_pkg::kp_count_t kp_count,
    output logic                   done
);
    import feature_pkg::*;

    logic      active;
    logic      wait_rd;    // row address changed, data one cycle away
    row_addr_t row;
    col_addr_t col;
    kp_count_t count;

    pixel_t    pix;
    pixel_t    blr;
    pixel_t    diff;
    thresh_t   thresh;
    logic      hit;

    // both memories stay on the same row while its columns are tested
    assign row_addr = row;

    assign pix    = img_dout[col*`FC_PIX_W +: `FC_PIX_W];
    assign blr    = blur_dout[col*`FC_PIX_W +: `FC_PIX_W];
    assign diff   = (pix > blr) ? (pix - blr) : (blr - pix);
    assign thresh = filter_on ? filter_threshold : thresh_t'(`FC_BASE_THRESH);
    assign hit    = active && !wait_rd && (diff > thresh);

    assign kp_we    = hit && (count < `FC_KP_DEPTH);    // drop hits once the store is full
    assign kp_addr  = kp_addr_t'(count);
    assign kp_din   = '{row: row, col: col};
    assign kp_count = count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active  <= 1'b0;
            wait_rd <= 1'b0;
            row     <= '0;
            col     <= '0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active  <= 1'b1;
                wait_rd <= 1'b1;
                row     <= '0;
                col     <= '0;
                count   <= '0;
            end else if (active) begin
                if (wait_rd) begin
                    wait_rd <= 1'b0;
                end else begin
                    if (kp_we) begin
                        count <= count + 1'b1;
                    end
                    if (col == col_addr_t'(`FC_IMG_COLS - 1)) begin
                        col <= '0;
                        if (row == row_addr_t'(`FC_IMG_ROWS - 1)) begin
                            active <= 1'b0;
                            done   <= 1'b1;    // last pixel tested
                        end else begin
                            row     <= row + 1'b1;
                            wait_rd <= 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* blur/gaussian_blur.sv */
`timescale 1ns/100ps
`include "feature_cfg.svh"

module gaussian_blur (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  feature_pkg::img_row_t  img_dout,
    output feature_pkg::row_addr_t img_addr,
    output logic                   blur_we,
    output feature_pkg::row_addr_t blur_addr,
    output feature_pkg::img_row_t  blur_din,
    output logic                   done
);
    import feature_pkg::*;

    logic       run;          // issuing row reads
    logic [4:0] step;         // rows 0..15, then 16 for the zero row
    logic       shift_d;      // memory data valid this cycle
    logic [4:0] step_d;
    logic       win_valid;    // window updated last edge
    logic [4:0] win_idx;      // newest step held in the window
    logic       lb_fill_zero;

    img_row_t win_above;
    img_row_t win_mid;
    img_row_t win_below;
    img_row_t blur_row;

    logic [`FC_PIX_W+1:0] vpad [`FC_IMG_COLS+2];    // vertical sums, zero at both ends
    logic [`FC_PIX_W+3:0] hsum [`FC_IMG_COLS];

    assign img_addr     = row_addr_t'(step);
    assign lb_fill_zero = start || (shift_d && step_d[4]);

    line_buffer i_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift_d),
        .fill_zero (lb_fill_zero),
        .row_in    (img_dout),
        .row_above (win_above),
        .row_mid   (win_mid),
        .row_below (win_below)
    );

    // separable 1-2-1, vertical pass first
    always_comb begin
        vpad[0]              = '0;
        vpad[`FC_IMG_COLS+1] = '0;
        for (int c = 0; c < `FC_IMG_COLS; c++) begin
            vpad[c+1] = {2'b00, win_above[c*`FC_PIX_W +: `FC_PIX_W]}
                      + {1'b0, win_mid[c*`FC_PIX_W +: `FC_PIX_W], 1'b0}
                      + {2'b00, win_below[c*`FC_PIX_W +: `FC_PIX_W]};
        end
        for (int c = 0; c < `FC_IMG_COLS; c++) begin
            hsum[c] = {2'b00, vpad[c]} + {1'b0, vpad[c+1], 1'b0} + {2'b00, vpad[c+2]};
            blur_row[c*`FC_PIX_W +: `FC_PIX_W] = hsum[c][`FC_PIX_W+3:4];    // truncating /16
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            step      <= '0;
            shift_d   <= 1'b0;
            step_d    <= '0;
            win_valid <= 1'b0;
            win_idx   <= '0;
            blur_we   <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (start) begin
                run  <= 1'b1;
                step <= '0;
            end else if (run) begin
                if (step == 5'(`FC_IMG_ROWS)) begin
                    run <= 1'b0;
                end
                step <= step + 5'd1;
            end
            shift_d   <= run;
            step_d    <= step;
            win_valid <= shift_d;
            win_idx   <= step_d;
            blur_we   <= win_valid && (win_idx != 5'd0);    // row below the middle is in
            done      <= blur_we && (blur_addr == row_addr_t'(`FC_IMG_ROWS - 1));
        end
    end

    always_ff @(posedge clk) begin
        blur_addr <= row_addr_t'(win_idx - 5'd1);    // middle row of the window
        blur_din  <= blur_row;
    end

endmodule

/* blur/line_buffer.sv */
`timescale 1ns/100ps

module line_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  shift,
    input  logic                  fill_zero,
    input  feature_pkg::img_row_t row_in,
    output feature_pkg::img_row_t row_above,
    output feature_pkg::img_row_t row_mid,
    output feature_pkg::img_row_t row_below
);

    // fill_zero alone empties the window, so the row above row 0 reads as zero;
    // fill_zero with shift pushes the bottom padding row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_above <= '0;
            row_mid   <= '0;
            row_below <= '0;
        end else if (fill_zero && !shift) begin
            row_above <= '0;
            row_mid   <= '0;
            row_below <= '0;
        end else if (shift) begin
            row_above <= row_mid;
            row_mid   <= row_below;
            if (fill_zero) begin
                row_below <= '0;    // past the last image row
            end else begin
                row_below <= row_in;
            end
        end
    end

endmodule

/* source/feature_sequencer.sv */
`timescale 1ns/100ps

module feature_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  feature_pkg::img_load_t img_load,
    input  logic                   blur_done,
    input  logic                   detect_done,
    input  feature_pkg::row_addr_t blur_img_addr,
    input  feature_pkg::row_addr_t det_img_addr,
    input  feature_pkg::kp_addr_t  kp_rd_addr,
    input  feature_pkg::kp_addr_t  det_kp_addr,
    output feature_pkg::phase_e    phase,
    output logic                   blur_start,
    output logic                   detect_start,
    output logic                   img_we,
    output feature_pkg::row_addr_t img_addr,
    output feature_pkg::kp_addr_t  kp_addr,
    output logic                   done
);
    import feature_pkg::*;

    phase_e phase_next;
    logic   host_owns;    // memories belong to the host
    logic   start_ok;

    assign host_owns = (phase == PH_IDLE) || (phase == PH_DONE);
    assign start_ok  = start && host_owns;    // start mid-run is dropped

    always_comb begin
        phase_next = phase;
        case (phase)
            PH_IDLE, PH_DONE: begin
                if (start_ok) begin
                    phase_next = PH_BLUR;
                end
            end
            PH_BLUR: begin
                if (blur_done) begin
                    phase_next = PH_DETECT;
                end
            end
            PH_DETECT: begin
                if (detect_done) begin
                    phase_next = PH_DONE;
                end
            end
            default: begin
                phase_next = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase        <= PH_IDLE;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
        end else begin
            phase        <= phase_next;
            blur_start   <= start_ok;                            // first cycle of blur
            detect_start <= (phase == PH_BLUR) && blur_done;     // first cycle of detect
        end
    end

    // image memory port steering
    always_comb begin
        case (phase)
            PH_BLUR: begin
                img_addr = blur_img_addr;
            end
            PH_DETECT: begin
                img_addr = det_img_addr;
            end
            default: begin
                img_addr = img_load.addr;
            end
        endcase
    end

    assign img_we  = img_load.we && host_owns;    // host writes blocked during a run
    assign kp_addr = (phase == PH_DETECT) ? det_kp_addr : kp_rd_addr;
    assign done    = (phase == PH_DONE);

endmodule

/* source/row_ram.sv */
`timescale 1ns/100ps

module row_ram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];    // read before write on same address
    end

endmodule

/* common/feature_pkg.sv */
`include "feature_cfg.svh"

package feature_pkg;

    typedef logic [`FC_PIX_W-1:0]               pixel_t;
    typedef logic [`FC_IMG_COLS*`FC_PIX_W-1:0]  img_row_t;    // column 0 in low byte
    typedef logic [$clog2(`FC_IMG_ROWS)-1:0]    row_addr_t;
    typedef logic [$clog2(`FC_IMG_COLS)-1:0]    col_addr_t;
    typedef logic [`FC_PIX_W-1:0]               thresh_t;
    typedef logic [$clog2(`FC_KP_DEPTH)-1:0]    kp_addr_t;
    typedef logic [$clog2(`FC_KP_DEPTH):0]      kp_count_t;   // 0 to full depth

    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
    } keypoint_t;

    // host write port of the image memory
    typedef struct packed {
        logic      we;
        row_addr_t addr;
        img_row_t  data;
    } img_load_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_BLUR,
        PH_DETECT,
        PH_DONE
    } phase_e;

endpackage

/* common/feature_cfg.svh */
`ifndef FEATURE_CFG_SVH
`define FEATURE_CFG_SVH

// image geometry
`define FC_IMG_ROWS 16
`define FC_IMG_COLS 16

// grayscale sample width
`define FC_PIX_W 8

// keypoint store, also the saturation point of the count
`define FC_KP_DEPTH 64

// detection threshold while the filter switch is off
`define FC_BASE_THRESH 8

`endif
